//--- nic_ctrl_top.f
+incdir+.
nic_ctrl_pkg.sv
reg_write_decode.sv
reset_pause_timers.sv
packet_stats.sv
reg_read_mux.sv
nic_ctrl_top.sv
tb_clock_gen.sv
tb_nic_ctrl.sv

//--- Bender.yml
package:
  name: nic_ctrl_top

export_include_dirs:
  - .

sources:
  - nic_ctrl_pkg.sv
  - reg_write_decode.sv
  - reset_pause_timers.sv
  - packet_stats.sv
  - reg_read_mux.sv
  - nic_ctrl_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_nic_ctrl.sv

//--- tb_nic_ctrl.sv
`timescale 1ns/1ns
`include "nic_ctrl_cfg.svh"

module tb_nic_ctrl;

    localparam int DRIVE_DELAY = 10;
    localparam int RSP_TIMEOUT = 8;

    logic clk;
    logic resetn;

    // DUT inputs
    nic_ctrl_pkg::host_wr_t    wr_req;
    nic_ctrl_pkg::host_rd_t    rd_req;
    nic_ctrl_pkg::pkt_events_t events;
    nic_ctrl_pkg::seq_beat_t   seq_beat;
    logic overflow_0;
    logic overflow_1;
    logic generator_idle;
    logic xmit_idle;
    logic async_hbm_cattrip;
    logic async_pcs_aligned;

    // DUT outputs
    nic_ctrl_pkg::host_rsp_t   wr_rsp;
    nic_ctrl_pkg::host_rsp_t   rd_rsp;
    nic_ctrl_pkg::pci_window_t pci_window;
    nic_ctrl_pkg::xmit_cfg_t   xmit_cfg;
    logic [63:0] packet_count;
    logic gen_packets;
    logic xmit_start;
    logic loopback;
    logic resetn_out;
    logic pause_pci;

    // Pulse and level tallies taken mid-cycle
    int gen_pulses;
    int xmit_pulses;
    int pause_cycles_seen;
    int reset_cycles_seen;

    logic [31:0] rng_state;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    nic_ctrl_top UUT (
        .clk               (clk),
        .resetn            (resetn),
        .wr_req            (wr_req),
        .rd_req            (rd_req),
        .wr_rsp            (wr_rsp),
        .rd_rsp            (rd_rsp),
        .events            (events),
        .seq_beat          (seq_beat),
        .overflow_0        (overflow_0),
        .overflow_1        (overflow_1),
        .generator_idle    (generator_idle),
        .xmit_idle         (xmit_idle),
        .async_hbm_cattrip (async_hbm_cattrip),
        .async_pcs_aligned (async_pcs_aligned),
        .packet_count      (packet_count),
        .gen_packets       (gen_packets),
        .xmit_start        (xmit_start),
        .loopback          (loopback),
        .resetn_out        (resetn_out),
        .pause_pci         (pause_pci),
        .pci_window        (pci_window),
        .xmit_cfg          (xmit_cfg)
    );

    // Falling edge sits in the middle of the cycle, outputs are settled
    always @(negedge clk) begin
        if (gen_packets)
            gen_pulses++;
        if (xmit_start)
            xmit_pulses++;
        if (pause_pci)
            pause_cycles_seen++;
        if (!resetn_out)
            reset_cycles_seen++;
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Strobe for one cycle, then wait for the response pulse
    task automatic reg_write(input logic [7:0] index, input logic [31:0] data,
                             output logic [1:0] code);
        int waited;
        wr_req.strobe = 1'b1;
        wr_req.index  = index;
        wr_req.data   = data;
        next_cycle();
        wr_req.strobe = 1'b0;
        waited = 0;
        while (!wr_rsp.valid && waited < RSP_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (wr_rsp.valid) else begin
            $display("no write response for index %0d within %0d cycles", index, RSP_TIMEOUT);
            abort_run();
        end
        // A write response carries no data
        check_value($sformatf("wr_rsp.data for index %0d", index), 64'd0, wr_rsp.data);
        code = wr_rsp.code;
    endtask

    task automatic reg_read(input logic [7:0] index, output logic [31:0] data,
                            output logic [1:0] code);
        int waited;
        rd_req.strobe = 1'b1;
        rd_req.index  = index;
        next_cycle();
        rd_req.strobe = 1'b0;
        waited = 0;
        while (!rd_rsp.valid && waited < RSP_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (rd_rsp.valid) else begin
            $display("no read response for index %0d within %0d cycles", index, RSP_TIMEOUT);
            abort_run();
        end
        data = rd_rsp.data;
        code = rd_rsp.code;
    endtask

    task automatic write_ok(input logic [7:0] index, input logic [31:0] data);
        logic [1:0] code;
        reg_write(index, data, code);
        check_value($sformatf("wr_rsp.code for index %0d", index), `RESP_OKAY, code);
    endtask

    task automatic read_expect(input logic [7:0] index, input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  code;
        reg_read(index, data, code);
        check_value($sformatf("rd_rsp.code for index %0d", index), `RESP_OKAY, code);
        check_value($sformatf("rd_rsp.data for index %0d", index), expected, data);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_defaults();
        logic [63:0] exp_base;
        logic [63:0] exp_size;
        logic [63:0] exp_src;
        logic [63:0] exp_dst;
        logic [63:0] exp_len;
        logic [7:0]  cfg_index [10];
        logic [31:0] cfg_word [10];
        exp_base = `PCI_BASE_DEFAULT;
        exp_size = `PCI_SIZE_DEFAULT;
        exp_src  = `XMIT_SRC_DEFAULT;
        exp_dst  = `XMIT_DST_DEFAULT;
        exp_len  = `XMIT_SIZE_DEFAULT;
        // Window and descriptor halves, high half first as in the structs
        cfg_index = '{`REG_PCI_BASE_H, `REG_PCI_BASE_L, `REG_PCI_SIZE_H, `REG_PCI_SIZE_L,
                      `REG_XMIT_SRCADDR_H, `REG_XMIT_SRCADDR_L, `REG_XMIT_DSTADDR_H,
                      `REG_XMIT_DSTADDR_L, `REG_XMIT_SIZE_H, `REG_XMIT_SIZE_L};
        read_expect(`REG_PCI_BASE_H, exp_base[63:32]);
        read_expect(`REG_PCI_BASE_L, exp_base[31:0]);
        read_expect(`REG_PCI_SIZE_H, exp_size[63:32]);
        read_expect(`REG_PCI_SIZE_L, exp_size[31:0]);
        read_expect(`REG_XMIT_SRCADDR_H, exp_src[63:32]);
        read_expect(`REG_XMIT_SRCADDR_L, exp_src[31:0]);
        read_expect(`REG_XMIT_DSTADDR_H, exp_dst[63:32]);
        read_expect(`REG_XMIT_DSTADDR_L, exp_dst[31:0]);
        read_expect(`REG_XMIT_SIZE_H, exp_len[63:32]);
        read_expect(`REG_XMIT_SIZE_L, exp_len[31:0]);
        read_expect(`REG_LOOPBACK, 32'd0);
        check_value("loopback", 64'd0, loopback);
        for (int i = 0; i < 10; i++) begin
            cfg_word[i] = next_random();
            write_ok(cfg_index[i], cfg_word[i]);
        end
        for (int i = 2; i < 10; i++)
            read_expect(cfg_index[i], cfg_word[i]);
        read_expect(cfg_index[0], cfg_word[0]);
        read_expect(cfg_index[1], cfg_word[1]);
        check_value("pci_window.base", {cfg_word[0], cfg_word[1]}, pci_window.base);
        check_value("pci_window.size", {cfg_word[2], cfg_word[3]}, pci_window.size);
        check_value("xmit_cfg.src_addr", {cfg_word[4], cfg_word[5]}, xmit_cfg.src_addr);
        check_value("xmit_cfg.dst_addr", {cfg_word[6], cfg_word[7]}, xmit_cfg.dst_addr);
        check_value("xmit_cfg.byte_count", {cfg_word[8], cfg_word[9]}, xmit_cfg.byte_count);
        write_ok(`REG_LOOPBACK, 32'd1);
        check_value("loopback", 64'd1, loopback);
        read_expect(`REG_LOOPBACK, 32'd1);
    endtask

    task automatic test_decode_errors();
        logic [31:0] data;
        logic [1:0]  code;
        reg_write(8'd50, next_random(), code);
        check_value("wr_rsp.code for index 50", `RESP_DECERR, code);
        reg_read(8'd50, data, code);
        check_value("rd_rsp.code for index 50", `RESP_DECERR, code);
        // Write-only register reads as unmapped
        reg_read(`REG_CLEAR_COUNTERS, data, code);
        check_value("rd_rsp.code for CLEAR_COUNTERS", `RESP_DECERR, code);
        reg_write(`REG_LOOPBACK, 32'd0, code);
        check_value("wr_rsp.code for LOOPBACK", `RESP_OKAY, code);
    endtask

    task automatic test_command_pulses();
        logic [31:0] count_hi;
        logic [31:0] count_lo;
        count_hi = next_random();
        count_lo = next_random();
        gen_pulses  = 0;
        xmit_pulses = 0;
        write_ok(`REG_PACKET_COUNT_H, count_hi);
        next_cycle();
        check_value("gen_packets pulses", 0, gen_pulses);
        write_ok(`REG_PACKET_COUNT_L, count_lo);
        next_cycle();
        next_cycle();
        check_value("packet_count", {count_hi, count_lo}, packet_count);
        check_value("gen_packets pulses", 1, gen_pulses);
        write_ok(`REG_XMIT_START, 32'd1);
        next_cycle();
        next_cycle();
        check_value("xmit_start pulses", 1, xmit_pulses);
        // Bit 0 clear must not start a transmit
        write_ok(`REG_XMIT_START, 32'd2);
        next_cycle();
        next_cycle();
        check_value("xmit_start pulses", 1, xmit_pulses);
        // Busy bits read back on the command registers
        generator_idle = 1'b0;
        xmit_idle      = 1'b0;
        read_expect(`REG_PACKET_COUNT_L, 32'd1);
        read_expect(`REG_XMIT_START, 32'd1);
        generator_idle = 1'b1;
        xmit_idle      = 1'b1;
        read_expect(`REG_PACKET_COUNT_L, 32'd0);
    endtask

    task automatic send_beat(input logic [31:0] word);
        seq_beat.data  = word;
        seq_beat.valid = 1'b1;
        seq_beat.ready = 1'b1;
        next_cycle();
        seq_beat.valid = 1'b0;
    endtask

    task automatic test_statistics();
        int n_good;
        int n_bad;
        n_good = 1 + (next_random() % 12);
        n_bad  = 1 + (next_random() % 12);
        for (int i = 0; i < 12; i++) begin
            events.good_pkt  = (i < n_good);
            events.bad_pkt   = (i < n_bad);
            events.range_err = (i == 3);
            next_cycle();
        end
        events = '0;
        read_expect(`REG_GOOD_PACKETS_H, 32'd0);
        read_expect(`REG_GOOD_PACKETS_L, n_good);
        read_expect(`REG_BAD_PACKETS_H, 32'd0);
        read_expect(`REG_BAD_PACKETS_L, n_bad);
        read_expect(`REG_ERRORS, 32'h1);
        // Running counter in order, then one skipped value
        send_beat(32'd5);
        send_beat(32'd6);
        send_beat(32'd7);
        read_expect(`REG_ERRORS, 32'h1);
        send_beat(32'd9);
        read_expect(`REG_ERRORS, 32'h9);
        write_ok(`REG_CLEAR_COUNTERS, 32'd1);
        next_cycle();
        read_expect(`REG_GOOD_PACKETS_L, 32'd0);
        read_expect(`REG_BAD_PACKETS_L, 32'd0);
        read_expect(`REG_ERRORS, 32'h0);
        // Overflow inputs pass straight to bits 1 and 2
        overflow_0 = 1'b1;
        read_expect(`REG_ERRORS, 32'h2);
        overflow_0 = 1'b0;
        overflow_1 = 1'b1;
        read_expect(`REG_ERRORS, 32'h4);
        overflow_1 = 1'b0;
    endtask

    task automatic test_timers();
        int waited;
        pause_cycles_seen = 0;
        write_ok(`REG_PAUSE_PCI, 32'd20);
        waited = 0;
        while (pause_pci && waited < 40) begin
            next_cycle();
            waited++;
        end
        assert (!pause_pci) else begin
            $display("pause_pci stayed high beyond 40 cycles");
            abort_run();
        end
        check_value("pause_pci high cycles", 20, pause_cycles_seen);
        // Count one packet so the system reset has something to clear
        events.good_pkt = 1'b1;
        next_cycle();
        events = '0;
        read_expect(`REG_GOOD_PACKETS_L, 32'd1);
        reset_cycles_seen = 0;
        write_ok(`REG_RESET, 32'd1);
        waited = 0;
        while (resetn_out && waited < 4) begin
            next_cycle();
            waited++;
        end
        assert (!resetn_out) else begin
            $display("resetn_out did not go low after the RESET write");
            abort_run();
        end
        read_expect(`REG_RESET, 32'd1);
        waited = 0;
        while (!resetn_out && waited < 1100) begin
            next_cycle();
            waited++;
        end
        assert (resetn_out) else begin
            $display("resetn_out stayed low beyond 1100 cycles");
            abort_run();
        end
        check_value("resetn_out low cycles", `RESET_PULSE_CYCLES, reset_cycles_seen);
        read_expect(`REG_RESET, 32'd0);
        read_expect(`REG_GOOD_PACKETS_L, 32'd0);
    endtask

    task automatic test_status_sync();
        logic [31:0] data;
        logic [1:0]  code;
        int tries;
        // Not aligned and cattrip set reads all zero
        read_expect(`REG_STATUS, 32'd0);
        async_pcs_aligned = 1'b1;
        async_hbm_cattrip = 1'b0;
        tries = 0;
        data  = 32'd0;
        while (data != 32'd3 && tries < 6) begin
            reg_read(`REG_STATUS, data, code);
            tries++;
        end
        check_value("STATUS after synchronizer", 32'd3, data);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int waited;
        wr_req            = '0;
        rd_req            = '0;
        events            = '0;
        seq_beat          = '0;
        overflow_0        = 1'b0;
        overflow_1        = 1'b0;
        generator_idle    = 1'b1;
        xmit_idle         = 1'b1;
        async_hbm_cattrip = 1'b1;
        async_pcs_aligned = 1'b0;
        rng_state         = 32'd47;
        gen_pulses        = 0;
        xmit_pulses       = 0;
        pause_cycles_seen = 0;
        reset_cycles_seen = 0;

        waited = 0;
        while (resetn !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        assert (resetn === 1'b1) else begin
            $display("reset was never released");
            abort_run();
        end
        next_cycle();

        test_reset_defaults();
        test_decode_errors();
        test_command_pulses();
        test_statistics();
        test_timers();
        test_status_sync();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 100 ns clock period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held low for the first two rising edges
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #10 resetn = 1'b1;
    end

endmodule

//--- nic_ctrl_top.sv
`timescale 1ns/1ns

module nic_ctrl_top (
    input  logic                      clk,
    input  logic                      resetn,

    // Host register port
    input  nic_ctrl_pkg::host_wr_t    wr_req,
    input  nic_ctrl_pkg::host_rd_t    rd_req,
    output nic_ctrl_pkg::host_rsp_t   wr_rsp,
    output nic_ctrl_pkg::host_rsp_t   rd_rsp,

    // Receive path events and buffer output monitor
    input  nic_ctrl_pkg::pkt_events_t events,
    input  nic_ctrl_pkg::seq_beat_t   seq_beat,

    // Status from the rest of the NIC
    input  logic                      overflow_0,
    input  logic                      overflow_1,
    input  logic                      generator_idle,
    input  logic                      xmit_idle,
    input  logic                      async_hbm_cattrip,
    input  logic                      async_pcs_aligned,

    // Controls to the rest of the NIC
    output logic [63:0]               packet_count,
    output logic                      gen_packets,
    output logic                      xmit_start,
    output logic                      loopback,
    output logic                      resetn_out,
    output logic                      pause_pci,
    output nic_ctrl_pkg::pci_window_t pci_window,
    output nic_ctrl_pkg::xmit_cfg_t   xmit_cfg
);

    // Command pulses from the write decoder
    logic        clear_counters;
    logic        reset_req;
    logic        pause_load;
    logic [31:0] pause_cycles;

    // Status gathered for readback
    logic        reset_active;
    logic [63:0] good_packets;
    logic [63:0] bad_packets;
    logic        range_err;
    logic        seq_error;

    reg_write_decode u_reg_write_decode (
        .clk            (clk),
        .resetn         (resetn),
        .wr_req         (wr_req),
        .wr_rsp         (wr_rsp),
        .packet_count   (packet_count),
        .gen_packets    (gen_packets),
        .xmit_start     (xmit_start),
        .loopback       (loopback),
        .clear_counters (clear_counters),
        .reset_req      (reset_req),
        .pause_load     (pause_load),
        .pause_cycles   (pause_cycles),
        .pci_window     (pci_window),
        .xmit_cfg       (xmit_cfg)
    );

    reset_pause_timers u_reset_pause_timers (
        .clk          (clk),
        .resetn       (resetn),
        .reset_req    (reset_req),
        .pause_load   (pause_load),
        .pause_cycles (pause_cycles),
        .resetn_out   (resetn_out),
        .reset_active (reset_active),
        .pause_pci    (pause_pci)
    );

    // Statistics live in the system reset domain
    packet_stats u_packet_stats (
        .clk            (clk),
        .resetn_out     (resetn_out),
        .clear_counters (clear_counters),
        .events         (events),
        .seq_beat       (seq_beat),
        .good_packets   (good_packets),
        .bad_packets    (bad_packets),
        .range_err      (range_err),
        .seq_error      (seq_error)
    );

    reg_read_mux u_reg_read_mux (
        .clk               (clk),
        .resetn            (resetn),
        .rd_req            (rd_req),
        .good_packets      (good_packets),
        .bad_packets       (bad_packets),
        .range_err         (range_err),
        .seq_error         (seq_error),
        .overflow_0        (overflow_0),
        .overflow_1        (overflow_1),
        .generator_idle    (generator_idle),
        .xmit_idle         (xmit_idle),
        .async_hbm_cattrip (async_hbm_cattrip),
        .async_pcs_aligned (async_pcs_aligned),
        .reset_active      (reset_active),
        .pause_pci         (pause_pci),
        .loopback          (loopback),
        .pci_window        (pci_window),
        .xmit_cfg          (xmit_cfg),
        .rd_rsp            (rd_rsp)
    );

endmodule

//--- reg_read_mux.sv
`timescale 1ns/1ns
`include "nic_ctrl_cfg.svh"

module reg_read_mux (
    input  logic                      clk,
    input  logic                      resetn,
    input  nic_ctrl_pkg::host_rd_t    rd_req,
    input  logic [63:0]               good_packets,
    input  logic [63:0]               bad_packets,
    input  logic                      range_err,
    input  logic                      seq_error,
    input  logic                      overflow_0,
    input  logic                      overflow_1,
    input  logic                      generator_idle,
    input  logic                      xmit_idle,
    input  logic                      async_hbm_cattrip,
    input  logic                      async_pcs_aligned,
    input  logic                      reset_active,
    input  logic                      pause_pci,
    input  logic                      loopback,
    input  nic_ctrl_pkg::pci_window_t pci_window,
    input  nic_ctrl_pkg::xmit_cfg_t   xmit_cfg,
    output nic_ctrl_pkg::host_rsp_t   rd_rsp
);

    // Bit 1 is the HBM cattrip, bit 0 is PCS alignment
    logic [1:0]  sync_meta;
    logic [1:0]  sync_out;
    logic        temp_ok;
    logic        pcs_aligned;

    nic_ctrl_pkg::err_word_u err_word;
    logic [31:0] rd_word;
    logic        rd_hit;

    // ==============================
    // Two-flop synchronizers
    // ==============================
    always_ff @(posedge clk) begin
        sync_meta <= {async_hbm_cattrip, async_pcs_aligned};
        sync_out  <= sync_meta;
    end

    assign temp_ok     = ~sync_out[1];
    assign pcs_aligned = sync_out[0];

    // ==============================
    // Read word select
    // ==============================
    always_comb begin
        err_word                  = '0;
        err_word.flags.range_err  = range_err;
        err_word.flags.overflow_0 = overflow_0;
        err_word.flags.overflow_1 = overflow_1;
        err_word.flags.seq_error  = seq_error;

        rd_word = 32'd0;
        rd_hit  = 1'b1;
        case (rd_req.index)
            `REG_STATUS:         rd_word = {30'd0, temp_ok, pcs_aligned};
            `REG_ERRORS:         rd_word = err_word.raw;
            `REG_GOOD_PACKETS_H: rd_word = good_packets[63:32];
            `REG_GOOD_PACKETS_L: rd_word = good_packets[31:0];
            `REG_BAD_PACKETS_H:  rd_word = bad_packets[63:32];
            `REG_BAD_PACKETS_L:  rd_word = bad_packets[31:0];
            `REG_PCI_BASE_H:     rd_word = pci_window.base[63:32];
            `REG_PCI_BASE_L:     rd_word = pci_window.base[31:0];
            `REG_PCI_SIZE_H:     rd_word = pci_window.size[63:32];
            `REG_PCI_SIZE_L:     rd_word = pci_window.size[31:0];
            `REG_RESET:          rd_word = {31'd0, reset_active};
            `REG_XMIT_SRCADDR_H: rd_word = xmit_cfg.src_addr[63:32];
            `REG_XMIT_SRCADDR_L: rd_word = xmit_cfg.src_addr[31:0];
            `REG_XMIT_DSTADDR_H: rd_word = xmit_cfg.dst_addr[63:32];
            `REG_XMIT_DSTADDR_L: rd_word = xmit_cfg.dst_addr[31:0];
            `REG_XMIT_SIZE_H:    rd_word = xmit_cfg.byte_count[63:32];
            `REG_XMIT_SIZE_L:    rd_word = xmit_cfg.byte_count[31:0];
            // Busy bits read back on the command registers
            `REG_XMIT_START:     rd_word = {31'd0, ~xmit_idle};
            `REG_PACKET_COUNT_L: rd_word = {31'd0, ~generator_idle};
            `REG_LOOPBACK:       rd_word = {31'd0, loopback};
            `REG_PAUSE_PCI:      rd_word = {31'd0, pause_pci};
            // CLEAR_COUNTERS and PACKET_COUNT_H are write-only
            default:             rd_hit  = 1'b0;
        endcase
    end

    // Response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_rsp.valid <= 1'b0;
        end else begin
            rd_rsp.valid <= rd_req.strobe;
            if (rd_req.strobe) begin
                rd_rsp.data <= rd_word;
                rd_rsp.code <= rd_hit ? `RESP_OKAY : `RESP_DECERR;
            end
        end
    end

endmodule

//--- packet_stats.sv
`timescale 1ns/1ns

module packet_stats (
    input  logic                      clk,
    input  logic                      resetn_out,
    input  logic                      clear_counters,
    input  nic_ctrl_pkg::pkt_events_t events,
    input  nic_ctrl_pkg::seq_beat_t   seq_beat,
    output logic [63:0]               good_packets,
    output logic [63:0]               bad_packets,
    output logic                      range_err,
    output logic                      seq_error
);

    // Counter word of the previous accepted beat
    logic [31:0] seq_prior;
    // Set once a beat has been seen since the last clear
    logic        seq_primed;
    logic        beat_taken;

    assign beat_taken = seq_beat.valid & seq_beat.ready;

    // ==============================
    // Packet counters and sticky range error
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn_out || clear_counters) begin
            good_packets <= 64'd0;
            bad_packets  <= 64'd0;
            range_err    <= 1'b0;
        end else begin
            if (events.good_pkt)
                good_packets <= good_packets + 64'd1;
            if (events.bad_pkt)
                bad_packets <= bad_packets + 64'd1;
            if (events.range_err)
                range_err <= 1'b1;
        end
    end

    // ==============================
    // Sequence monitor on the buffer output
    // ==============================
    // Generated packets carry a running counter in the top word,
    // a zero word marks data that carries no counter
    always_ff @(posedge clk) begin
        if (!resetn_out || clear_counters) begin
            seq_error  <= 1'b0;
            seq_primed <= 1'b0;
        end else if (beat_taken) begin
            seq_primed <= 1'b1;
            if (seq_primed && seq_beat.data != 32'd0 && seq_beat.data != seq_prior + 32'd1)
                seq_error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_taken)
            seq_prior <= seq_beat.data;
    end

endmodule

//--- reset_pause_timers.sv
`timescale 1ns/1ns
`include "nic_ctrl_cfg.svh"

module reset_pause_timers (
    input  logic        clk,
    input  logic        resetn,
    input  logic        reset_req,
    input  logic        pause_load,
    input  logic [31:0] pause_cycles,
    output logic        resetn_out,
    output logic        reset_active,
    output logic        pause_pci
);

    logic [15:0] reset_count;
    logic [15:0] reset_count_next;
    logic [31:0] pause_count;

    // Next reset count, so resetn_out can follow it without an extra cycle
    always_comb begin
        if (reset_req)
            reset_count_next = `RESET_PULSE_CYCLES;
        else if (reset_count != 16'd0)
            reset_count_next = reset_count - 16'd1;
        else
            reset_count_next = 16'd0;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            reset_count <= 16'd0;
            resetn_out  <= 1'b0;
            pause_count <= 32'd0;
        end else begin
            reset_count <= reset_count_next;
            resetn_out  <= (reset_count_next == 16'd0);

            // The load cycle itself counts as the first paused cycle
            if (pause_load)
                pause_count <= (pause_cycles != 32'd0) ? pause_cycles - 32'd1 : 32'd0;
            else if (pause_count != 32'd0)
                pause_count <= pause_count - 32'd1;
        end
    end

    assign reset_active = (reset_count != 16'd0);

    // High in the load cycle so the pause starts with the command pulse
    assign pause_pci = pause_load ? (pause_cycles != 32'd0) : (pause_count != 32'd0);

endmodule

//--- reg_write_decode.sv
`timescale 1ns/1ns
`include "nic_ctrl_cfg.svh"

module reg_write_decode (
    input  logic                      clk,
    input  logic                      resetn,
    input  nic_ctrl_pkg::host_wr_t    wr_req,
    output nic_ctrl_pkg::host_rsp_t   wr_rsp,
    output logic [63:0]               packet_count,
    output logic                      gen_packets,
    output logic                      xmit_start,
    output logic                      loopback,
    output logic                      clear_counters,
    output logic                      reset_req,
    output logic                      pause_load,
    output logic [31:0]               pause_cycles,
    output nic_ctrl_pkg::pci_window_t pci_window,
    output nic_ctrl_pkg::xmit_cfg_t   xmit_cfg
);

    // ==============================
    // Write decode
    // ==============================
    always_ff @(posedge clk) begin
        // Commands are single-cycle pulses
        gen_packets    <= 1'b0;
        xmit_start     <= 1'b0;
        clear_counters <= 1'b0;
        reset_req      <= 1'b0;
        pause_load     <= 1'b0;
        wr_rsp.valid   <= wr_req.strobe;

        if (!resetn) begin
            wr_rsp.valid          <= 1'b0;
            loopback              <= 1'b0;
            pci_window.base       <= `PCI_BASE_DEFAULT;
            pci_window.size       <= `PCI_SIZE_DEFAULT;
            xmit_cfg.src_addr     <= `XMIT_SRC_DEFAULT;
            xmit_cfg.dst_addr     <= `XMIT_DST_DEFAULT;
            xmit_cfg.byte_count   <= `XMIT_SIZE_DEFAULT;
        end else if (wr_req.strobe) begin
            // Mapped indexes answer OKAY, the default branch overrides
            wr_rsp.code <= `RESP_OKAY;
            wr_rsp.data <= 32'd0;

            case (wr_req.index)
                // Buffer window halves
                `REG_PCI_BASE_H: pci_window.base[63:32] <= wr_req.data;
                `REG_PCI_BASE_L: pci_window.base[31:0]  <= wr_req.data;
                `REG_PCI_SIZE_H: pci_window.size[63:32] <= wr_req.data;
                `REG_PCI_SIZE_L: pci_window.size[31:0]  <= wr_req.data;

                // Transmit descriptor halves
                `REG_XMIT_SRCADDR_H: xmit_cfg.src_addr[63:32]   <= wr_req.data;
                `REG_XMIT_SRCADDR_L: xmit_cfg.src_addr[31:0]    <= wr_req.data;
                `REG_XMIT_DSTADDR_H: xmit_cfg.dst_addr[63:32]   <= wr_req.data;
                `REG_XMIT_DSTADDR_L: xmit_cfg.dst_addr[31:0]    <= wr_req.data;
                `REG_XMIT_SIZE_H:    xmit_cfg.byte_count[63:32] <= wr_req.data;
                `REG_XMIT_SIZE_L:    xmit_cfg.byte_count[31:0]  <= wr_req.data;

                // Only bit 0 starts a transmit
                `REG_XMIT_START: xmit_start <= wr_req.data[0];

                `REG_PACKET_COUNT_H: packet_count[63:32] <= wr_req.data;

                // Low half completes the request and kicks the generator
                `REG_PACKET_COUNT_L: begin
                    packet_count[31:0] <= wr_req.data;
                    gen_packets        <= 1'b1;
                end

                `REG_LOOPBACK: loopback <= wr_req.data[0];

                // The timers module owns the pulse length
                `REG_RESET: reset_req <= 1'b1;

                `REG_PAUSE_PCI: begin
                    pause_load   <= 1'b1;
                    pause_cycles <= wr_req.data;
                end

                `REG_CLEAR_COUNTERS: clear_counters <= 1'b1;

                // Status and counters are read-only, anything else unmapped
                default: wr_rsp.code <= `RESP_DECERR;
            endcase
        end
    end

endmodule

//--- nic_ctrl_pkg.sv
package nic_ctrl_pkg;

    // ==============================
    // Host register port
    // ==============================

    // Write strobe with the register index and the word to store
    typedef struct packed {
        logic        strobe;
        logic [7:0]  index;
        logic [31:0] data;
    } host_wr_t;

    // Read strobe with the register index
    typedef struct packed {
        logic       strobe;
        logic [7:0] index;
    } host_rd_t;

    // One-cycle response to either strobe
    typedef struct packed {
        logic        valid;
        logic [1:0]  code;
        logic [31:0] data;
    } host_rsp_t;

    // ==============================
    // NIC-side configuration and events
    // ==============================

    // Contiguous buffer window in host RAM
    typedef struct packed {
        logic [63:0] base;
        logic [63:0] size;
    } pci_window_t;

    // Descriptor for a transmit out of the QSFP port
    typedef struct packed {
        logic [63:0] src_addr;
        logic [63:0] dst_addr;
        logic [63:0] byte_count;
    } xmit_cfg_t;

    // Single-cycle strobes from the receive path
    typedef struct packed {
        logic good_pkt;
        logic bad_pkt;
        logic range_err;
    } pkt_events_t;

    // Top 32 bits of a buffer output beat, plus its handshake
    typedef struct packed {
        logic [31:0] data;
        logic        valid;
        logic        ready;
    } seq_beat_t;

    // ERRORS register, flag fields listed MSB first
    typedef struct packed {
        logic [27:0] reserved;
        logic        seq_error;
        logic        overflow_1;
        logic        overflow_0;
        logic        range_err;
    } err_flags_t;

    typedef union packed {
        logic [31:0] raw;
        err_flags_t  flags;
    } err_word_u;

endpackage

//--- nic_ctrl_cfg.svh
`ifndef NIC_CTRL_CFG_SVH
`define NIC_CTRL_CFG_SVH

// ==============================
// Register map, one 32-bit word per index
// ==============================
`define REG_STATUS          8'd0
`define REG_ERRORS          8'd1
`define REG_GOOD_PACKETS_H  8'd2
`define REG_GOOD_PACKETS_L  8'd3
`define REG_BAD_PACKETS_H   8'd4
`define REG_BAD_PACKETS_L   8'd5
`define REG_PCI_BASE_H      8'd6
`define REG_PCI_BASE_L      8'd7
`define REG_PCI_SIZE_H      8'd8
`define REG_PCI_SIZE_L      8'd9
`define REG_RESET           8'd10
`define REG_CLEAR_COUNTERS  8'd11

// Transmit descriptor and its start command
`define REG_XMIT_SRCADDR_H  8'd20
`define REG_XMIT_SRCADDR_L  8'd21
`define REG_XMIT_DSTADDR_H  8'd22
`define REG_XMIT_DSTADDR_L  8'd23
`define REG_XMIT_SIZE_H     8'd24
`define REG_XMIT_SIZE_L     8'd25
`define REG_XMIT_START      8'd26

// Packet generator and data-path controls
`define REG_PACKET_COUNT_H  8'd32
`define REG_PACKET_COUNT_L  8'd33
`define REG_LOOPBACK        8'd34
`define REG_PAUSE_PCI       8'd35

// Length of the system reset pulse in clock cycles
`define RESET_PULSE_CYCLES  16'd1000

// Response codes on the register port
`define RESP_OKAY           2'd0
`define RESP_DECERR         2'd3

// ==============================
// Values loaded while resetn is low
// ==============================
`define PCI_BASE_DEFAULT    64'h0000_0001_0000_0000
`define PCI_SIZE_DEFAULT    64'h0000_0001_0000_0000
`define XMIT_SRC_DEFAULT    64'h0000_0001_0000_0000
`define XMIT_DST_DEFAULT    64'h0000_0000_0000_0000
`define XMIT_SIZE_DEFAULT   64'h0000_0000_0010_0000

`endif
